/* verilog/oled_term_pkg.sv */
package oled_term_pkg;

    localparam int SCREEN_W = 96;
    localparam int SCREEN_H = 64;

    localparam int TEXT_COLS = 12;
    localparam int TEXT_ROWS = 4;
    localparam int TEXT_CELLS = TEXT_COLS * TEXT_ROWS;

    localparam int GLYPH_COUNT = 17;
    localparam int GLYPH_ROWS = 8;
    localparam int SPACE_GLYPH = 0;

    localparam int CLKS_PER_BIT = 108;
    localparam int SPI_CLKS_PER_BIT = 2;
    localparam int RESET_CLKS = 32;
    localparam int INIT_CMD_COUNT = 8;

    // Display off, 8 bit colour remap, start line 0, offset 0, display on
    localparam logic [7:0] INIT_CMDS [INIT_CMD_COUNT] = '{
        8'hae, 8'ha0, 8'h20, 8'ha1, 8'h00, 8'ha2, 8'h00, 8'haf
    };

    typedef struct packed {
        logic [6:0] x;
        logic [5:0] y;
    } pixel_pos_t;

    typedef enum logic [1:0] {idle, start, data, stop} uart_state_t;

    typedef enum logic {wait_char, advance} cursor_state_t;

    typedef enum logic [1:0] {reset_panel, send_cmd, send_pixels} oled_state_t;

endpackage

/* verilog/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx
    import oled_term_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    uart_state_t                       state;
    logic [$clog2(CLKS_PER_BIT)-1:0]   bit_timer;
    logic [2:0]                        bit_idx;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= idle;
            bit_timer <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_valid <= 1'b0;
            bit_timer <= bit_timer + 1'b1;
            case (state)
                idle:
                begin
                    bit_timer <= '0;
                    if (!rx)
                        state <= start;
                end
                start:
                begin
                    if (int'(bit_timer) == CLKS_PER_BIT / 2 - 1) // Middle of the start bit
                    begin
                        bit_timer <= '0;
                        bit_idx <= '0;
                        state <= rx ? idle : data; // A glitch is not a start bit
                    end
                end
                data:
                begin
                    if (int'(bit_timer) == CLKS_PER_BIT - 1)
                    begin
                        bit_timer <= '0;
                        rx_data <= {rx, rx_data[7:1]}; // LSB arrives first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= stop;
                    end
                end
                stop:
                begin
                    if (int'(bit_timer) == CLKS_PER_BIT - 1)
                    begin
                        rx_valid <= rx; // Framing error drops the byte
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

/* verilog/text_buffer.sv */
`timescale 1ns/1ps

module text_buffer
    import oled_term_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  pixel_pos_t pos,
    output logic [7:0] char_code
);

    logic [7:0]    mem [TEXT_CELLS];
    cursor_state_t state;
    logic [3:0]    cur_col;
    logic [1:0]    cur_row;
    logic [7:0]    wr_data;
    logic [5:0]    wr_addr;
    logic [5:0]    rd_addr;

    assign wr_addr = 6'(cur_row) * 6'(TEXT_COLS) + 6'(cur_col);
    assign rd_addr = 6'(pos.y[5:4]) * 6'(TEXT_COLS) + 6'(pos.x[6:3]); // 8x16 pixel cells

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= wait_char;
            cur_col <= '0;
            cur_row <= '0;
            for (int i = 0; i < TEXT_CELLS; i++)
                mem[i] <= 8'h20; // ASCII space
        end
        else
        begin
            case (state)
                wait_char:
                begin
                    if (rx_valid)
                    begin
                        wr_data <= rx_data;
                        state <= advance;
                    end
                end
                advance:
                begin
                    mem[wr_addr] <= wr_data;
                    state <= wait_char;
                    if (int'(cur_col) == TEXT_COLS - 1)
                    begin
                        cur_col <= '0;
                        cur_row <= (int'(cur_row) == TEXT_ROWS - 1) ? '0 : cur_row + 1'b1;
                    end
                    else
                        cur_col <= cur_col + 1'b1;
                end
                default: state <= wait_char;
            endcase
        end
    end

    always_ff @(posedge clk)
        char_code <= mem[rd_addr];

    a_cursor_col: assert property (@(posedge clk) disable iff (!rst_n)
        int'(cur_col) < TEXT_COLS);

    // The driver's scan must stay inside the panel or the read leaves the buffer
    a_pos_in_panel: assert property (@(posedge clk) disable iff (!rst_n)
        int'(pos.x) < SCREEN_W);

endmodule

/* verilog/glyph_pixel.sv */
`timescale 1ns/1ps

module glyph_pixel
    import oled_term_pkg::*;
(
    input  logic       clk,
    input  logic [7:0] char_code,
    input  pixel_pos_t pos,
    output logic       pixel_on
);

    logic [7:0] font [GLYPH_COUNT * GLYPH_ROWS];
    logic [4:0] glyph;
    logic [7:0] font_addr;
    logic [7:0] font_row;

    initial
        $readmemh("verilog/font.mem", font);

    function automatic logic [4:0] glyph_index(input logic [7:0] code);
        logic [4:0] idx;
        idx = 5'(SPACE_GLYPH);
        if (code >= 8'h30 && code <= 8'h39)
            idx = 5'(code - 8'h2f); // '0' is glyph 1
        else if (code >= 8'h41 && code <= 8'h46)
            idx = 5'(code - 8'h36); // 'A' is glyph 11
        return idx;
    endfunction

    assign glyph = glyph_index(char_code);
    assign font_addr = 8'(glyph) * 8'(GLYPH_ROWS) + 8'(pos.y[3:1]); // Each stored row is shown twice
    assign font_row = font[font_addr];

    always_ff @(posedge clk)
        pixel_on <= font_row[3'd7 - pos.x[2:0]];

endmodule

/* verilog/oled_driver.sv */
`timescale 1ns/1ps

module oled_driver
    import oled_term_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pixel_on,
    output pixel_pos_t pos,
    output logic       csn,
    output logic       spi_clk,
    output logic       mosi,
    output logic       dc,
    output logic       resn
);

    oled_state_t                    state;
    logic [$clog2(RESET_CLKS)-1:0]  reset_cnt;
    logic [3:0]                     phase;
    logic [2:0]                     cmd_idx;
    logic [7:0]                     shift_reg;
    logic [7:0]                     pixel_byte;
    logic                           byte_end;
    logic                           last_cmd;
    pixel_pos_t                     next_pos;

    assign byte_end = (phase == 4'(8 * SPI_CLKS_PER_BIT - 1));
    assign last_cmd = (int'(cmd_idx) == INIT_CMD_COUNT - 1);
    assign spi_clk = csn | phase[0]; // Falls at the start of every bit, idles high
    assign mosi = shift_reg[7];

    always_comb
    begin
        next_pos = pos;
        if (int'(pos.x) == SCREEN_W - 1)
        begin
            next_pos.x = '0;
            next_pos.y = (int'(pos.y) == SCREEN_H - 1) ? '0 : pos.y + 1'b1;
        end
        else
            next_pos.x = pos.x + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= reset_panel;
            reset_cnt <= '0;
            phase <= '0;
            cmd_idx <= '0;
            pos <= '0;
            csn <= 1'b1;
            resn <= 1'b0;
            dc <= 1'b0;
        end
        else
        begin
            case (state)
                reset_panel:
                begin
                    reset_cnt <= reset_cnt + 1'b1;
                    if (int'(reset_cnt) == RESET_CLKS - 1)
                    begin
                        resn <= 1'b1;
                        csn <= 1'b0;
                        state <= send_cmd;
                    end
                end
                send_cmd:
                begin
                    phase <= phase + 1'b1;
                    if (byte_end)
                    begin
                        cmd_idx <= cmd_idx + 1'b1;
                        if (last_cmd)
                        begin
                            dc <= 1'b1;
                            pos <= next_pos; // Pixel 0 was fetched during the last command
                            state <= send_pixels;
                        end
                    end
                end
                send_pixels:
                begin
                    phase <= phase + 1'b1;
                    if (byte_end)
                        pos <= next_pos;
                end
                default: state <= reset_panel;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase == 4'd3)
            pixel_byte <= pixel_on ? 8'hff : 8'h00; // White or black in RGB332
        if (state == reset_panel)
            shift_reg <= INIT_CMDS[0];
        else if (byte_end)
            shift_reg <= (state == send_cmd && !last_cmd) ? INIT_CMDS[cmd_idx + 3'd1] : pixel_byte;
        else if (phase[0])
            shift_reg <= {shift_reg[6:0], 1'b0};
    end

    a_cmd_dc_low: assert property (@(posedge clk) disable iff (!rst_n)
        state == send_cmd |-> !dc);

endmodule

/* verilog/oled_term.sv */
`timescale 1ns/1ps

module oled_term
    import oled_term_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic csn,
    output logic spi_clk,
    output logic mosi,
    output logic dc,
    output logic resn
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] char_code;
    logic       pixel_on;
    pixel_pos_t pos;
    pixel_pos_t pos_d;

    // Aligns the position with char_code, which is one cycle behind pos
    always_ff @(posedge clk)
        pos_d <= pos;

    uart_rx i_uart_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    text_buffer i_text_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .pos       (pos),
        .char_code (char_code)
    );

    glyph_pixel i_glyph_pixel (
        .clk       (clk),
        .char_code (char_code),
        .pos       (pos_d),
        .pixel_on  (pixel_on)
    );

    oled_driver i_oled_driver (
        .clk      (clk),
        .rst_n    (rst_n),
        .pixel_on (pixel_on),
        .pos      (pos),
        .csn      (csn),
        .spi_clk  (spi_clk),
        .mosi     (mosi),
        .dc       (dc),
        .resn     (resn)
    );

endmodule

/* tests/oled_term_check.sv */
`timescale 1ns/1ps

module oled_term_check
    import oled_term_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        csn,
    input  logic        spi_clk,
    input  logic        mosi,
    input  logic        dc,
    input  logic        resn,
    input  logic        busy,
    input  logic        wr_strobe,
    input  logic [7:0]  wr_byte,
    input  logic        wr_good,
    input  logic [95:0] test_name,
    output int          frames_checked,
    output int          pixel_errors,
    output int          cmd_errors,
    output int          reset_errors,
    output int          cmd_count
);

    localparam int FRAME_PIXELS = SCREEN_W * SCREEN_H;
    localparam int MAX_REPORTS = 8;

    logic [7:0] font [GLYPH_COUNT * GLYPH_ROWS];
    logic [7:0] model [TEXT_CELLS];
    logic [7:0] frame_cells [TEXT_CELLS];
    logic [7:0] got [FRAME_PIXELS];
    logic [7:0] shift;
    logic       prev_sclk;
    logic       prev_resn;
    logic       dirty;
    int         cursor;
    int         bit_cnt;
    int         pix_idx;
    int         resn_low;

    initial
        $readmemh("verilog/font.mem", font);

    function automatic int glyph_of(input logic [7:0] code);
        if (code >= 8'h30 && code <= 8'h39)
            return int'(code) - 'h30 + 1; // Digits follow the space glyph
        if (code >= 8'h41 && code <= 8'h46)
            return int'(code) - 'h41 + 11;
        return SPACE_GLYPH;
    endfunction

    function automatic logic [7:0] expected_pixel(input int x, input int y);
        logic [7:0] code;
        logic [7:0] row;
        code = frame_cells[(y / 16) * TEXT_COLS + x / 8];
        row = font[glyph_of(code) * GLYPH_ROWS + (y % 16) / 2]; // Stored rows are doubled
        return row[7 - x % 8] ? 8'hff : 8'h00;
    endfunction

    task automatic compare_frame();
        int reports;
        logic [7:0] exp;
        reports = 0;
        for (int p = 0; p < FRAME_PIXELS; p++)
        begin
            exp = expected_pixel(p % SCREEN_W, p / SCREEN_W);
            if (got[p] !== exp)
            begin
                pixel_errors++;
                if (reports < MAX_REPORTS)
                    $display("mismatch %0s expected %02h actual %02h at x %0d y %0d",
                             test_name, exp, got[p], p % SCREEN_W, p / SCREEN_W);
                reports++;
            end
        end
    endtask

    task automatic take_byte(input logic is_data, input logic [7:0] b);
        if (!is_data)
        begin
            if (cmd_count < INIT_CMD_COUNT)
            begin
                if (b !== INIT_CMDS[cmd_count])
                begin
                    cmd_errors++;
                    $display("mismatch %0s expected %02h actual %02h", test_name,
                             INIT_CMDS[cmd_count], b);
                end
            end
            else
            begin
                cmd_errors++;
                $display("command byte %02h went out after the init list", b);
            end
            cmd_count++;
        end
        else
        begin
            if (pix_idx == 0)
            begin
                frame_cells = model; // Text seen by this frame
                dirty = busy;
            end
            got[pix_idx] = b;
            pix_idx++;
            if (pix_idx == FRAME_PIXELS)
            begin
                pix_idx = 0;
                if (!dirty)
                begin
                    compare_frame();
                    frames_checked++;
                end
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < TEXT_CELLS; i++)
                model[i] = 8'h20;
            cursor = 0;
            bit_cnt = 0;
            pix_idx = 0;
            resn_low = 0;
            shift = '0;
            prev_sclk = 1'b1;
            prev_resn = 1'b0;
            dirty = 1'b1;
            frames_checked = 0;
            pixel_errors = 0;
            cmd_errors = 0;
            reset_errors = 0;
            cmd_count = 0;
        end
        else
        begin
            if (busy)
                dirty = 1'b1; // A frame that overlaps a UART byte is not compared
            if (wr_strobe && wr_good)
            begin
                model[cursor] = wr_byte;
                cursor = (cursor + 1) % TEXT_CELLS;
            end
            if (!resn && (csn !== 1'b1 || spi_clk !== 1'b1))
            begin
                reset_errors++;
                $display("chip select or SPI clock left its idle level during the panel reset");
            end
            if (!resn)
                resn_low++;
            else if (!prev_resn && resn_low != RESET_CLKS)
            begin
                reset_errors++;
                $display("mismatch %0s expected %0d actual %0d", test_name, RESET_CLKS, resn_low);
            end
            if (!csn && spi_clk && !prev_sclk)
            begin
                shift = {shift[6:0], mosi}; // MSB first
                bit_cnt++;
                if (bit_cnt == 8)
                begin
                    take_byte(dc, shift);
                    bit_cnt = 0;
                end
            end
            prev_sclk = spi_clk;
            prev_resn = resn;
        end
    end

endmodule

/* tests/oled_term_tb.sv */
`timescale 1ns/1ps

module oled_term_tb
    import oled_term_pkg::*;
;

    localparam int MAX_ENTRIES = 64;
    localparam int TEST_COUNT = 6;
    localparam int FRAME_CLKS = SCREEN_W * SCREEN_H * 8 * SPI_CLKS_PER_BIT;
    localparam int BYTE_CLKS = 11 * CLKS_PER_BIT + 2;
    localparam int TIMEOUT_CLKS = TEST_COUNT * 3 * FRAME_CLKS + MAX_ENTRIES * BYTE_CLKS + 20000;

    logic        clk;
    logic        rst_n;
    logic        rx;
    logic        csn;
    logic        spi_clk;
    logic        mosi;
    logic        dc;
    logic        resn;
    logic        busy;
    logic        wr_strobe;
    logic        wr_good;
    logic [7:0]  wr_byte;
    logic [95:0] test_name;
    int          frames_checked;
    int          pixel_errors;
    int          cmd_errors;
    int          reset_errors;
    int          cmd_count;

    logic [95:0] tbl_name [MAX_ENTRIES];
    logic [7:0]  tbl_byte [MAX_ENTRIES];
    logic        tbl_good [MAX_ENTRIES];
    int          n_entries;
    int          seed;
    int          errors;
    int          cycles;

    oled_term i_oled_term (
        .clk     (clk),
        .rst_n   (rst_n),
        .rx      (rx),
        .csn     (csn),
        .spi_clk (spi_clk),
        .mosi    (mosi),
        .dc      (dc),
        .resn    (resn)
    );

    oled_term_check i_oled_term_check (
        .clk            (clk),
        .rst_n          (rst_n),
        .csn            (csn),
        .spi_clk        (spi_clk),
        .mosi           (mosi),
        .dc             (dc),
        .resn           (resn),
        .busy           (busy),
        .wr_strobe      (wr_strobe),
        .wr_byte        (wr_byte),
        .wr_good        (wr_good),
        .test_name      (test_name),
        .frames_checked (frames_checked),
        .pixel_errors   (pixel_errors),
        .cmd_errors     (cmd_errors),
        .reset_errors   (reset_errors),
        .cmd_count      (cmd_count)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles == TIMEOUT_CLKS)
        begin
            $display("timeout after %0d cycles while waiting for a clean frame", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic add_entry(input logic [95:0] name, input logic [7:0] code, input logic good);
        tbl_name[n_entries] = name;
        tbl_byte[n_entries] = code;
        tbl_good[n_entries] = good;
        n_entries++;
    endtask

    task automatic build_table();
        for (int i = 0; i < 4; i++)
            add_entry("digits", 8'h30 + 8'(i), 1'b1);
        for (int i = 4; i < 10; i++)
            add_entry("wrap_col", 8'h30 + 8'(i), 1'b1);
        add_entry("wrap_col", 8'h41, 1'b1);
        add_entry("wrap_col", 8'h42, 1'b1);
        add_entry("wrap_col", 8'h43, 1'b1); // Thirteenth byte starts row 1
        add_entry("bad_codes", 8'h61, 1'b1);
        add_entry("bad_codes", 8'h7a, 1'b1);
        add_entry("bad_codes", 8'h47, 1'b1);
        for (int i = 0; i < 6; i++)
            add_entry("bad_codes", 8'($random(seed)), 1'b1);
        add_entry("framing", 8'h46, 1'b0);
        add_entry("framing", 8'h45, 1'b1);
        for (int i = 0; i < 25; i++)
            add_entry("wrap_top", 8'($random(seed)), 1'b1); // Fills up to cell 47
        add_entry("wrap_top", 8'h44, 1'b1);
    endtask

    task automatic drive_bit(input logic value);
        rx <= value;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] code, input logic good);
        @(posedge clk);
        busy <= 1'b1;
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(code[i]);
        drive_bit(good); // A low stop bit is a framing error
        drive_bit(1'b1);
        wr_byte <= code;
        wr_good <= good;
        wr_strobe <= 1'b1;
        @(posedge clk);
        wr_strobe <= 1'b0;
        busy <= 1'b0;
    endtask

    task automatic wait_clean_frame();
        int target;
        target = frames_checked + 1;
        while (frames_checked < target)
            @(posedge clk);
    endtask

    initial
    begin
        rx = 1'b1;
        rst_n = 1'b0;
        busy = 1'b0;
        wr_strobe = 1'b0;
        wr_good = 1'b0;
        wr_byte = '0;
        test_name = "reset";
        errors = 0;
        cycles = 0;
        n_entries = 0;
        seed = 32'h9af6_0493;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        wait_clean_frame(); // First frame shows an empty screen
        for (int i = 0; i < n_entries; i++)
        begin
            test_name <= tbl_name[i];
            send_frame(tbl_byte[i], tbl_good[i]);
            if (i == n_entries - 1 || tbl_name[i + 1] != tbl_name[i])
                wait_clean_frame();
        end
        if (cmd_count != INIT_CMD_COUNT)
        begin
            errors++;
            $display("the panel received %0d command bytes instead of %0d",
                     cmd_count, INIT_CMD_COUNT);
        end
        $display("errors: pixel %0d command %0d reset %0d other %0d, frames checked %0d",
                 pixel_errors, cmd_errors, reset_errors, errors, frames_checked);
        if (pixel_errors + cmd_errors + reset_errors + errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* verilog/font.mem */
// One glyph row per line, MSB is the leftmost pixel
// Eight rows per glyph in the order space, 0 to 9, A to F
00
00
00
00
00
00
00
00
3c
66
6e
76
66
66
3c
00
18
38
18
18
18
18
7e
00
3c
66
06
0c
30
60
7e
00
3c
66
06
1c
06
66
3c
00
0c
1c
3c
6c
7e
0c
0c
00
7e
60
7c
06
06
66
3c
00
3c
60
7c
66
66
66
3c
00
7e
06
0c
18
30
30
30
00
3c
66
66
3c
66
66
3c
00
3c
66
66
3e
06
0c
38
00
18
3c
66
66
7e
66
66
00
7c
66
66
7c
66
66
7c
00
3c
66
60
60
60
66
3c
00
78
6c
66
66
66
6c
78
00
7e
60
60
7c
60
60
7e
00
7e
60
60
7c
60
60
60
00

/* oled_term.f */
verilog/oled_term_pkg.sv
verilog/uart_rx.sv
verilog/text_buffer.sv
verilog/glyph_pixel.sv
verilog/oled_driver.sv
verilog/oled_term.sv
tests/oled_term_check.sv
tests/oled_term_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module oled_term_tb -f oled_term.f -o oled_term_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/oled_term_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0
